// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lb_switch
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@! grep -q "Testbench failed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/cell_fifo.sv
`timescale 1ns/100ps

module cell_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          do_wr;
    logic          do_rd;

    assign do_wr   = wr_en & ~full;     // Writes to a full FIFO are dropped
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem[rd_ptr];       // Fall-through head

    always_comb begin
        case ({do_wr, do_rd})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            empty <= (count_next == '0);
            full  <= (count_next == CW'(DEPTH));
        end
    end

endmodule

// File: hw/demux_ctrl.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module demux_ctrl
    import lb_pkg::*;
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  port_t                                    cnt,
    input  port_t [`PORT_NUB_TOTAL-1:0]              rx_sel,
    input  logic  [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] voq_empty_q,
    input  logic  [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_full,
    output port_t [`PORT_NUB_TOTAL-1:0]              voq_rd_sel,
    output port_t [`PORT_NUB_TOTAL-1:0]              voq_rd_sel_f,
    output logic  [`PORT_NUB_TOTAL-1:0]              voq_rd_en
);

    localparam int N = `PORT_NUB_TOTAL;

    port_t [N-1:0] sel;
    port_t [N-1:0] sel_f;
    logic  [N-1:0] sel_vld;     // Stage holds a real cnt sample
    logic  [N-1:0] sel_vld_f;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Staggered select chain where input i sees cnt delayed i+1 cycles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel       <= '0;
            sel_f     <= '0;
            sel_vld   <= '0;
            sel_vld_f <= '0;
        end else begin
            sel[0]     <= cnt;
            sel_vld[0] <= 1'b1;
            for (int i = 1; i < N; i++) begin
                sel[i]     <= sel[i-1];
                sel_vld[i] <= sel_vld[i-1];
            end
            sel_f     <= sel;
            sel_vld_f <= sel_vld;
        end
    end

    // The zeros left by reset repeat one VOQ on back-to-back cycles,
    // which would pop it twice against one staged cell. Hold off until
    // the chain carries live samples.
    always_comb begin
        for (int i = 0; i < N; i++) begin
            voq_rd_en[i] = sel_vld_f[i]
                         & ~voq_empty_q[i*N + int'(sel_f[i])]
                         & ~mid_full[int'(rx_sel[i])*N + int'(sel_f[i])];
        end
    end

    assign voq_rd_sel   = sel;      // Prefetch address
    assign voq_rd_sel_f = sel_f;    // Pop address one cycle later

endmodule

// File: hw/egress_drain.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module egress_drain
    import lb_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  port_t      [`PORT_NUB_TOTAL-1:0]                tx_sel,
    input  logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_empty,
    input  mid_cell_t  [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_rd_data,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_rd_en,
    output logic       [`PORT_NUB_TOTAL-1:0]                out_valid,
    output cell_data_t [`PORT_NUB_TOTAL-1:0]                out_data,
    output port_t      [`PORT_NUB_TOTAL-1:0]                out_src
);

    localparam int N = `PORT_NUB_TOTAL;

    logic      [N-1:0] hit;         // Output o receives a cell this cycle
    mid_cell_t [N-1:0] cell_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Second-stage crossbar
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int idx;
        mid_rd_en = '0;
        hit       = '0;
        cell_next = '0;
        for (int m = 0; m < N; m++) begin
            idx = m*N + int'(tx_sel[m]);
            if (!mid_empty[idx]) begin
                mid_rd_en[idx]    = 1'b1;
                hit[tx_sel[m]]    = 1'b1;
                cell_next[tx_sel[m]] = mid_rd_data[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < N; o++) begin
            if (hit[o]) begin
                out_data[o] <= cell_next[o].data;
                out_src[o]  <= cell_next[o].src;
            end
        end
    end

endmodule

// File: hw/lb_config.svh
`ifndef LB_CONFIG_SVH
`define LB_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Switch sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PORT_NUB_TOTAL 4    // Ports per stage (at least 2)

`define CELL_WIDTH 16       // Cell payload bits

// Buffer depths
`define VOQ_DEPTH 4         // Entries per virtual output queue
`define MID_DEPTH 2         // Entries per middle FIFO

// Middle FIFOs stay shallow as N of them feed each output

`endif

// File: hw/lb_pkg.sv
`include "lb_config.svh"

package lb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port index and cell formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int PORT_W = $clog2(`PORT_NUB_TOTAL);

    typedef logic [PORT_W-1:0] port_t;

    typedef logic [`CELL_WIDTH-1:0] cell_data_t;

    // Destination is implied by the VOQ holding the cell
    typedef struct packed {
        cell_data_t data;
    } voq_cell_t;

    // Source tag travels with the cell past the first stage
    typedef struct packed {
        cell_data_t data;
        port_t      src;
    } mid_cell_t;

endpackage

// File: hw/lb_switch_top.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module lb_switch_top
    import lb_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic       [`PORT_NUB_TOTAL-1:0]                in_valid,
    input  port_t      [`PORT_NUB_TOTAL-1:0]                in_dest,
    input  cell_data_t [`PORT_NUB_TOTAL-1:0]                in_data,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] voq_full,
    output logic       [`PORT_NUB_TOTAL-1:0]                out_valid,
    output cell_data_t [`PORT_NUB_TOTAL-1:0]                out_data,
    output port_t      [`PORT_NUB_TOTAL-1:0]                out_src
);

    localparam int N = `PORT_NUB_TOTAL;

    port_t                cnt;
    port_t      [N-1:0]   rx_sel;
    port_t      [N-1:0]   tx_sel;
    port_t      [N-1:0]   voq_rd_sel;
    port_t      [N-1:0]   voq_rd_sel_f;
    logic       [N-1:0]   voq_rd_en;
    logic       [N*N-1:0] voq_empty_q;
    cell_data_t [N-1:0]   mid_wr_data;
    logic       [N*N-1:0] mid_full;
    logic       [N*N-1:0] mid_empty;
    logic       [N*N-1:0] mid_rd_en;
    mid_cell_t  [N*N-1:0] mid_rd_data;

    slot_scheduler i_slot_scheduler (
        .clk    (clk),
        .rst_n  (rst_n),
        .cnt    (cnt),
        .rx_sel (rx_sel),
        .tx_sel (tx_sel)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // First stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    voq_ingress i_voq_ingress (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_dest      (in_dest),
        .in_data      (in_data),
        .voq_rd_sel   (voq_rd_sel),
        .voq_rd_sel_f (voq_rd_sel_f),
        .voq_rd_en    (voq_rd_en),
        .voq_empty_q  (voq_empty_q),
        .voq_full     (voq_full),
        .mid_wr_data  (mid_wr_data)
    );

    demux_ctrl i_demux_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cnt          (cnt),
        .rx_sel       (rx_sel),
        .voq_empty_q  (voq_empty_q),
        .mid_full     (mid_full),
        .voq_rd_sel   (voq_rd_sel),
        .voq_rd_sel_f (voq_rd_sel_f),
        .voq_rd_en    (voq_rd_en)
    );

    mid_buffer i_mid_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (voq_rd_en),
        .wr_mid    (rx_sel),
        .wr_out    (voq_rd_sel_f),
        .wr_data   (mid_wr_data),
        .rd_en     (mid_rd_en),
        .rd_data   (mid_rd_data),
        .mid_full  (mid_full),
        .mid_empty (mid_empty)
    );

    // Second stage
    egress_drain i_egress_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_sel      (tx_sel),
        .mid_empty   (mid_empty),
        .mid_rd_data (mid_rd_data),
        .mid_rd_en   (mid_rd_en),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_src     (out_src)
    );

endmodule

// File: hw/mid_buffer.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module mid_buffer
    import lb_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic       [`PORT_NUB_TOTAL-1:0]                wr_en,
    input  port_t      [`PORT_NUB_TOTAL-1:0]                wr_mid,
    input  port_t      [`PORT_NUB_TOTAL-1:0]                wr_out,
    input  cell_data_t [`PORT_NUB_TOTAL-1:0]                wr_data,
    input  logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] rd_en,
    output mid_cell_t  [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] rd_data,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_full,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] mid_empty
);

    localparam int N = `PORT_NUB_TOTAL;

    logic      [N*N-1:0] fifo_wr;
    mid_cell_t [N*N-1:0] fifo_wr_data;

    // wr_mid is a permutation so no FIFO sees two writers
    always_comb begin
        int idx;
        fifo_wr      = '0;
        fifo_wr_data = '0;
        for (int i = 0; i < N; i++) begin
            idx = int'(wr_mid[i])*N + int'(wr_out[i]);
            if (wr_en[i]) begin
                fifo_wr[idx]           = 1'b1;
                fifo_wr_data[idx].data = wr_data[i];
                fifo_wr_data[idx].src  = port_t'(i);  // Source tag
            end
        end
    end

    // FIFO (m, o) sits between middle port m and output o
    for (genvar k = 0; k < N*N; k++) begin : g_mid
        cell_fifo #(
            .payload_t (mid_cell_t),
            .DEPTH     (`MID_DEPTH)
        ) i_mid_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (fifo_wr[k]),
            .wr_data (fifo_wr_data[k]),
            .rd_en   (rd_en[k]),
            .rd_data (rd_data[k]),
            .empty   (mid_empty[k]),
            .full    (mid_full[k])
        );
    end

endmodule

// File: hw/slot_scheduler.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module slot_scheduler
    import lb_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    output port_t                        cnt,
    output port_t [`PORT_NUB_TOTAL-1:0]  rx_sel,
    output port_t [`PORT_NUB_TOTAL-1:0]  tx_sel
);

    localparam int N = `PORT_NUB_TOTAL;

    port_t cnt_next;

    // (base + offset) mod N
    function automatic port_t rotate(input port_t base, input int offset);
        int sum;
        sum = int'(base) + offset;
        return port_t'(sum % N);
    endfunction

    assign cnt_next = (cnt == port_t'(N - 1)) ? '0 : cnt + 1'b1;

    // Patterns are loaded from cnt_next so they line up with cnt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            for (int i = 0; i < N; i++) begin
                rx_sel[i] <= port_t'(i);
                tx_sel[i] <= port_t'(i);
            end
        end else begin
            cnt <= cnt_next;
            for (int i = 0; i < N; i++) begin
                rx_sel[i] <= rotate(cnt_next, i);   // Input i to middle port
                tx_sel[i] <= rotate(cnt_next, i);   // Middle port i to output
            end
        end
    end

endmodule

// File: hw/voq_ingress.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module voq_ingress
    import lb_pkg::*;
(
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic       [`PORT_NUB_TOTAL-1:0]               in_valid,
    input  port_t      [`PORT_NUB_TOTAL-1:0]               in_dest,
    input  cell_data_t [`PORT_NUB_TOTAL-1:0]               in_data,
    input  port_t      [`PORT_NUB_TOTAL-1:0]               voq_rd_sel,
    input  port_t      [`PORT_NUB_TOTAL-1:0]               voq_rd_sel_f,
    input  logic       [`PORT_NUB_TOTAL-1:0]               voq_rd_en,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] voq_empty_q,
    output logic       [`PORT_NUB_TOTAL*`PORT_NUB_TOTAL-1:0] voq_full,
    output cell_data_t [`PORT_NUB_TOTAL-1:0]               mid_wr_data
);

    localparam int N = `PORT_NUB_TOTAL;

    voq_cell_t [N-1:0]   in_cell;
    voq_cell_t [N*N-1:0] head;
    voq_cell_t [N-1:0]   stage;     // Prefetched head offered next cycle
    logic      [N*N-1:0] voq_wr;
    logic      [N*N-1:0] voq_rd;
    logic      [N*N-1:0] voq_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One VOQ per (input, destination)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < N; i++) begin : g_in
        assign in_cell[i].data = in_data[i];
        assign mid_wr_data[i]  = stage[i].data;

        for (genvar d = 0; d < N; d++) begin : g_voq
            assign voq_wr[i*N+d] = in_valid[i] & (in_dest[i] == port_t'(d));
            assign voq_rd[i*N+d] = voq_rd_en[i] & (voq_rd_sel_f[i] == port_t'(d));

            cell_fifo #(
                .payload_t (voq_cell_t),
                .DEPTH     (`VOQ_DEPTH)
            ) i_voq (
                .clk     (clk),
                .rst_n   (rst_n),
                .wr_en   (voq_wr[i*N+d]),
                .wr_data (in_cell[i]),
                .rd_en   (voq_rd[i*N+d]),
                .rd_data (head[i*N+d]),
                .empty   (voq_empty[i*N+d]),
                .full    (voq_full[i*N+d])
            );
        end
    end

    // Stage and snapshot on the same edge so both describe one instant
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            stage[i] <= head[i*N + int'(voq_rd_sel[i])];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            voq_empty_q <= '1;
        end else begin
            voq_empty_q <= voq_empty;
        end
    end

endmodule

// File: test/tb_lb_switch.sv
`timescale 1ns/100ps
`include "lb_config.svh"

module tb_lb_switch
    import lb_pkg::*;
();

    localparam int N           = `PORT_NUB_TOTAL;
    localparam int RAND_CELLS  = 160;
    localparam int HOT_CELLS   = 48;
    localparam int BURST_CELLS = 20;
    localparam int TOTAL_CELLS = 1 + N*N + RAND_CELLS + HOT_CELLS + BURST_CELLS;
    localparam int CYCLE_LIMIT = TOTAL_CELLS * N * (`VOQ_DEPTH + `MID_DEPTH) + 200;

    logic                 clk;
    logic                 rst_n;
    logic       [N-1:0]   in_valid;
    port_t      [N-1:0]   in_dest;
    cell_data_t [N-1:0]   in_data;
    logic       [N*N-1:0] voq_full;
    logic       [N-1:0]   out_valid;
    cell_data_t [N-1:0]   out_data;
    port_t      [N-1:0]   out_src;

    cell_data_t  exp_q [N*N][$];    // Outstanding cells per (source, destination)
    int          flow_dlvd [N*N];
    logic [31:0] rng;
    int          errors;
    int          sent_cnt;
    int          dlvd_cnt;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;
    int          test_err0;
    int          test_sent0;
    int          test_dlvd0;
    logic        quiet_mode;        // No output allowed
    logic        idle_mode;
    logic        hot_mode;
    logic        saw_mid_full;
    logic        saw_voq_full;
    port_t       hot_port;

    lb_switch_top i_lb_switch_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_dest   (in_dest),
        .in_data   (in_data),
        .voq_full  (voq_full),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_src   (out_src)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles with %0d cells still outstanding",
                 CYCLE_LIMIT, outstanding());
        $display("Testbench failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic cell_data_t next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return cell_data_t'(rng >> 16);     // Upper bits are the better ones
    endfunction

    function automatic int outstanding();
        int total;
        total = 0;
        for (int k = 0; k < N*N; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("mismatch %s: 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_cycle(input logic [N-1:0] want, input port_t [N-1:0] dest,
                               output logic [N-1:0] taken);
        logic       [N-1:0] v;
        cell_data_t [N-1:0] data;
        @(negedge clk);
        for (int i = 0; i < N; i++) begin
            // A cell on the inputs now lands in its VOQ at the next edge
            v[i] = want[i] && !voq_full[i*N + int'(dest[i])]
                 && !(in_valid[i] && in_dest[i] == dest[i]);
            data[i] = next_random();
        end
        @(posedge clk);
        for (int i = 0; i < N; i++) begin
            if (v[i]) begin
                exp_q[i*N + int'(dest[i])].push_back(data[i]);
                sent_cnt++;
            end
        end
        in_valid <= v;
        in_dest  <= dest;
        in_data  <= data;
        taken = v;
    endtask

    task automatic idle_cycles(input int cycles);
        logic [N-1:0] taken;
        repeat (cycles) drive_cycle('0, '0, taken);
    endtask

    task automatic wait_drain();
        logic [N-1:0] taken;
        while (outstanding() != 0) begin
            drive_cycle('0, '0, taken);
        end
        idle_cycles(2);
    endtask

    task automatic begin_test();
        test_err0    = errors;
        test_sent0   = sent_cnt;
        test_dlvd0   = dlvd_cnt;
        saw_mid_full = 1'b0;
        saw_voq_full = 1'b0;
        for (int k = 0; k < N*N; k++) begin
            flow_dlvd[k] = 0;
        end
    endtask

    task automatic end_test(input string name);
        int sent;
        int dlvd;
        sent = sent_cnt - test_sent0;
        dlvd = dlvd_cnt - test_dlvd0;
        check_value("delivered cells", dlvd, sent);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, sent %0d, delivered %0d", tests_run, name,
                 (errors == test_err0) ? "ok" : "FAILED", sent, dlvd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor and scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        int k;
        int hit;
        if (quiet_mode || idle_mode) begin
            check_value("out_valid", 32'(out_valid), 0);
        end
        if (rst_n) begin
            saw_mid_full = saw_mid_full | (|i_lb_switch_top.mid_full);
            saw_voq_full = saw_voq_full | (|voq_full);
            for (int o = 0; o < N; o++) begin
                if (out_valid[o]) begin
                    k   = int'(out_src[o])*N + o;   // Flow (source, output)
                    hit = -1;
                    for (int j = 0; j < exp_q[k].size(); j++) begin
                        if (hit < 0 && exp_q[k][j] == out_data[o]) hit = j;
                    end
                    assert (hit >= 0) else begin
                        $display("mismatch out_data[%0d]: 0x%h with out_src 0x%h, %s",
                                 o, out_data[o], out_src[o], "no such cell outstanding");
                        errors++;
                    end
                    if (hit >= 0) begin
                        exp_q[k].delete(hit);
                    end
                    flow_dlvd[k]++;
                    dlvd_cnt++;
                    if (hot_mode) begin
                        check_value("out_valid port", o, 32'(hot_port));
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic  [N-1:0] want;
        logic  [N-1:0] taken;
        port_t [N-1:0] dest;
        int            room;
        rng          = 32'h0747_b701;
        errors       = 0;
        sent_cnt     = 0;
        dlvd_cnt     = 0;
        tests_run    = 0;
        tests_failed = 0;
        quiet_mode   = 1'b1;
        idle_mode    = 1'b0;
        hot_mode     = 1'b0;
        saw_mid_full = 1'b0;
        saw_voq_full = 1'b0;
        hot_port     = '0;
        rst_n        = 1'b0;
        in_valid     = '0;
        in_dest      = '0;
        in_data      = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Single cell from input 0 to output 2
        begin_test();
        idle_cycles(4);
        check_value("voq_full", 32'(voq_full), 0);
        want    = '0;
        dest    = '0;
        want[0] = 1'b1;
        dest[0] = port_t'(2 % N);
        drive_cycle(want, dest, taken);
        quiet_mode = 1'b0;
        wait_drain();
        check_value("flow (0,2) deliveries", flow_dlvd[2 % N], 1);
        end_test("single cell");

        // One cell on every flow
        begin_test();
        for (int r = 0; r < N; r++) begin
            for (int i = 0; i < N; i++) begin
                dest[i] = port_t'((i + r) % N);
            end
            want = '1;
            while (want != '0) begin
                drive_cycle(want, dest, taken);
                want = want & ~taken;
            end
        end
        wait_drain();
        for (int k = 0; k < N*N; k++) begin
            check_value($sformatf("flow %0d deliveries", k), flow_dlvd[k], 1);
        end
        end_test("all flows");

        // Uniform traffic near 90 percent load
        begin_test();
        while (sent_cnt - test_sent0 < RAND_CELLS) begin
            room = RAND_CELLS - (sent_cnt - test_sent0);
            for (int i = 0; i < N; i++) begin
                want[i] = (room > 0) && (int'(next_random()) % 10 < 9);
                if (want[i]) room--;
                dest[i] = port_t'(int'(next_random()) % N);
            end
            drive_cycle(want, dest, taken);
        end
        wait_drain();
        end_test("random uniform");

        // Every input aims at one output
        begin_test();
        hot_port = port_t'(int'(next_random()) % N);
        hot_mode = 1'b1;
        while (sent_cnt - test_sent0 < HOT_CELLS) begin
            room = HOT_CELLS - (sent_cnt - test_sent0);
            for (int i = 0; i < N; i++) begin
                want[i] = (room > 0);
                if (want[i]) room--;
                dest[i] = hot_port;
            end
            drive_cycle(want, dest, taken);
        end
        wait_drain();
        hot_mode = 1'b0;
        assert (saw_mid_full) else begin
            $display("middle FIFOs never reached full under hotspot load");
            errors++;
        end
        end_test("hotspot");

        // Burst from one input into one VOQ
        begin_test();
        want          = '0;
        dest          = '0;
        want[1 % N]   = 1'b1;
        dest[1 % N]   = port_t'(N - 1);
        while (sent_cnt - test_sent0 < BURST_CELLS) begin
            drive_cycle(want, dest, taken);
        end
        wait_drain();
        @(negedge clk);
        check_value("voq_full", 32'(voq_full), 0);
        assert (saw_voq_full) else begin
            $display("voq_full never rose during the burst");
            errors++;
        end
        end_test("voq burst");

        // Quiet inputs must give quiet outputs
        begin_test();
        idle_mode = 1'b1;
        idle_cycles(4*N);
        idle_mode = 1'b0;
        end_test("idle");

        $display("tests %0d, failed %0d, cells sent %0d, delivered %0d, errors %0d",
                 tests_run, tests_failed, sent_cnt, dlvd_cnt, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/lb_pkg.sv
hw/cell_fifo.sv
hw/voq_ingress.sv
hw/slot_scheduler.sv
hw/demux_ctrl.sv
hw/mid_buffer.sv
hw/egress_drain.sv
hw/lb_switch_top.sv
test/tb_lb_switch.sv
